// File: Bender.yml
package:
  name: usb_sniffer

sources:
  - include_dirs:
      - src
    files:
      - src/sniffer_cmd_pkg.sv
      - src/sniffer_stream_pkg.sv
      - src/reg_req_if.sv
      - src/sync_fifo.sv
      - src/byte_counter.sv
      - src/reg_access.sv
      - src/tx_byte_select.sv
      - src/main_controller.sv
      - src/sniffer_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_sniffer.sv

// File: src/byte_counter.sv
// Byte counter
// Counts down the bytes of a header or packet body still to transmit
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

module byte_counter (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load,
    input  wire [`SNF_LEN_W-1:0] load_value,
    input  wire                  dec,
    output logic                 zero
);

    logic [`SNF_LEN_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;    // Load wins over a same-cycle dec
        end else if (dec && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign zero = (count == '0);

endmodule

`default_nettype wire

// File: src/main_controller.sv
// Sniffer main controller
// Takes host ops, runs PHY register accesses and sequences UART output
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

module main_controller (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 force_send,
    input  var sniffer_cmd_pkg::op_msg_t        op,
    input  wire                                 op_valid,
    output logic                                op_pop,
    input  var sniffer_stream_pkg::pkt_info_t   info,
    input  wire                                 info_valid,
    output logic                                info_pop,
    input  wire                                 data_valid,
    output logic                                data_pop,
    reg_req_if.controller                       req,
    output logic                                cnt_load,
    output logic [`SNF_LEN_W-1:0]               cnt_value,
    output logic                                cnt_dec,
    input  wire                                 cnt_zero,
    output logic                                info_load,
    output sniffer_stream_pkg::tx_sel_t         sel,
    output logic                                tx_valid,
    input  wire                                 tx_ready
);

    localparam logic [`SNF_LEN_W-1:0] HDR_BYTES = 2;

    typedef enum logic [2:0] {
        IDLE,
        REG_WAIT,
        REG_SEND,
        HDR_SEND,
        DATA_SEND
    } state_t;

    state_t state;
    state_t state_next;
    logic   hdr_lo;         // Second header byte is up
    logic   start_reg;

    always_comb begin
        state_next = state;
        op_pop     = 1'b0;
        info_pop   = 1'b0;
        data_pop   = 1'b0;
        cnt_load   = 1'b0;
        cnt_value  = '0;
        cnt_dec    = 1'b0;
        info_load  = 1'b0;
        start_reg  = 1'b0;
        tx_valid   = 1'b0;
        sel        = sniffer_stream_pkg::SEL_REG;
        case (state)
            IDLE: begin
                if (force_send) begin
                    state_next = REG_SEND;  // No op consumed
                end else if (op_valid) begin
                    case (op.opcode)
                        sniffer_cmd_pkg::OP_PKT_FWD: begin
                            // Op stays at the head until its info arrives
                            if (info_valid) begin
                                op_pop     = 1'b1;
                                info_load  = 1'b1;
                                cnt_load   = 1'b1;
                                cnt_value  = HDR_BYTES;
                                state_next = HDR_SEND;
                            end
                        end
                        sniffer_cmd_pkg::OP_REG_SEND: begin
                            op_pop     = 1'b1;
                            state_next = REG_SEND;
                        end
                        default: begin  // Register write or read
                            op_pop     = 1'b1;
                            start_reg  = 1'b1;
                            state_next = REG_WAIT;
                        end
                    endcase
                end
            end
            REG_WAIT: begin
                // busy is still low while the start pulse is out
                if (!req.busy && !req.start_write && !req.start_read)
                    state_next = IDLE;
            end
            REG_SEND: begin
                tx_valid = 1'b1;
                if (tx_ready)
                    state_next = IDLE;
            end
            HDR_SEND: begin
                tx_valid = 1'b1;
                sel = hdr_lo ? sniffer_stream_pkg::SEL_HDR_LO : sniffer_stream_pkg::SEL_HDR_HI;
                if (tx_ready) begin
                    cnt_dec = 1'b1;
                    if (hdr_lo) begin
                        // Info head still belongs to this packet
                        info_pop   = 1'b1;
                        cnt_load   = 1'b1;
                        cnt_value  = info.len;
                        state_next = DATA_SEND;
                    end
                end
            end
            DATA_SEND: begin
                sel      = sniffer_stream_pkg::SEL_DATA;
                tx_valid = data_valid && !cnt_zero;
                if (cnt_zero) begin
                    state_next = IDLE;
                end else if (tx_valid && tx_ready) begin
                    data_pop = 1'b1;
                    cnt_dec  = 1'b1;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state           <= IDLE;
            hdr_lo          <= 1'b0;
            req.start_write <= 1'b0;
            req.start_read  <= 1'b0;
        end else begin
            state           <= state_next;
            hdr_lo          <= (state == HDR_SEND) && (hdr_lo || tx_ready);
            req.start_write <= start_reg && (op.opcode == sniffer_cmd_pkg::OP_REG_WRITE);
            req.start_read  <= start_reg && (op.opcode == sniffer_cmd_pkg::OP_REG_READ);
        end
    end

    always_ff @(posedge clk) begin
        if (start_reg) begin
            req.addr  <= op.addr;
            req.wdata <= op.value;
        end
    end

endmodule

`default_nettype wire

// File: src/reg_access.sv
// PHY register port engine
// Holds one register request on the PHY strobe until done and keeps read data
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

module reg_access (
    input  wire                   clk,
    input  wire                   rst,
    reg_req_if.reg_access         req,
    output logic [`SNF_ADDR_W-1:0] phy_addr,
    output logic [7:0]            phy_wdata,
    output logic                  phy_write,
    output logic                  phy_read,
    input  wire [7:0]             phy_rdata,
    input  wire                   phy_done,
    output logic [7:0]            read_value
);

    logic start;

    assign start    = req.start_write || req.start_read;
    assign req.busy = phy_write || phy_read;    // Strobe up means busy

    always_ff @(posedge clk) begin
        if (!rst) begin
            phy_write  <= 1'b0;
            phy_read   <= 1'b0;
            read_value <= '0;
        end else if (req.busy) begin
            if (phy_done) begin
                phy_write <= 1'b0;
                phy_read  <= 1'b0;
                if (phy_read)
                    read_value <= phy_rdata;   // Kept for the send command
            end
        end else begin
            phy_write <= req.start_write;
            phy_read  <= req.start_read;
        end
    end

    // Address and data stay stable for the whole strobe
    always_ff @(posedge clk) begin
        if (start && !req.busy) begin
            phy_addr  <= req.addr;
            phy_wdata <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/reg_req_if.sv
// PHY register request bundle
// Controller starts an access and the register port reports busy
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

interface reg_req_if;

    logic [`SNF_ADDR_W-1:0] addr;
    logic [7:0]             wdata;
    logic                   start_write;   // One-cycle pulse
    logic                   start_read;    // One-cycle pulse
    logic                   busy;

    modport controller (output addr, wdata, start_write, start_read, input busy);
    modport reg_access (input addr, wdata, start_write, start_read, output busy);

endinterface

`default_nettype wire

// File: src/sniffer_cmd_pkg.sv
// Sniffer command types
// Opcode and layout of one 16-bit host command
`default_nettype none

`include "sniffer_consts.svh"

package sniffer_cmd_pkg;

    typedef enum logic [1:0] {
        OP_PKT_FWD   = 2'b00,   // Forward one captured packet
        OP_REG_SEND  = 2'b01,   // Send last value read
        OP_REG_WRITE = 2'b10,
        OP_REG_READ  = 2'b11
    } opcode_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [`SNF_ADDR_W-1:0]  addr;
        logic [7:0]              value;  // Write data, ignored otherwise
    } op_msg_t;

endpackage

`default_nettype wire

// File: src/sniffer_consts.svh
// Sniffer constants
// Field widths, FIFO depths and the PHY register range
`ifndef SNIFFER_CONSTS_SVH
`define SNIFFER_CONSTS_SVH

`define SNF_ADDR_W      6   // PHY register address
`define SNF_LEN_W       10  // Captured packet length
`define SNF_RXCMD_W     6   // RxCMD bits kept in the packet info

`define SNF_OP_DEPTH    4
`define SNF_INFO_DEPTH  4
`define SNF_DATA_DEPTH  16

`define SNF_REG_COUNT   (1 << `SNF_ADDR_W)

`endif

// File: src/sniffer_stream_pkg.sv
// Sniffer stream types
// Captured packet info and the source select of the UART byte
`default_nettype none

`include "sniffer_consts.svh"

package sniffer_stream_pkg;

    typedef struct packed {
        logic [`SNF_RXCMD_W-1:0] rxcmd;
        logic [`SNF_LEN_W-1:0]   len;    // Data bytes following the header
    } pkt_info_t;

    typedef enum logic [1:0] {
        SEL_REG,
        SEL_HDR_HI,     // {rxcmd, len[9:8]}
        SEL_HDR_LO,     // len[7:0]
        SEL_DATA
    } tx_sel_t;

endpackage

`default_nettype wire

// File: src/sniffer_top.sv
// USB sniffer command controller, top level
// Op, info and data FIFOs in front of the controller, PHY register port and UART byte out
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

module sniffer_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    force_send,
    input  wire [15:0]             op_data,
    input  wire                    op_valid,
    output logic                   op_ready,
    input  wire [15:0]             info_data,
    input  wire                    info_valid,
    output logic                   info_ready,
    input  wire [7:0]              usb_data,
    input  wire                    usb_valid,
    output logic                   usb_ready,
    output logic [`SNF_ADDR_W-1:0] phy_addr,
    output logic [7:0]             phy_wdata,
    output logic                   phy_write,
    output logic                   phy_read,
    input  wire [7:0]              phy_rdata,
    input  wire                    phy_done,
    output logic [7:0]             tx_data,
    output logic                   tx_valid,
    input  wire                    tx_ready
);

    sniffer_cmd_pkg::op_msg_t      op_head;
    sniffer_stream_pkg::pkt_info_t info_head;
    sniffer_stream_pkg::tx_sel_t   sel;
    logic [7:0]                    data_head;
    logic [7:0]                    read_value;
    logic [`SNF_LEN_W-1:0]         cnt_value;
    logic op_head_valid;
    logic info_head_valid;
    logic data_head_valid;
    logic op_pop;
    logic info_pop;
    logic data_pop;
    logic cnt_load;
    logic cnt_dec;
    logic cnt_zero;
    logic info_load;

    reg_req_if req_bus ();

    sync_fifo #(.payload_t(sniffer_cmd_pkg::op_msg_t), .DEPTH(`SNF_OP_DEPTH)) op_fifo_i (
        .clk(clk), .rst(rst),
        .in_data(op_data), .in_valid(op_valid), .in_ready(op_ready),
        .out_data(op_head), .out_valid(op_head_valid), .out_ready(op_pop)
    );

    sync_fifo #(.payload_t(sniffer_stream_pkg::pkt_info_t), .DEPTH(`SNF_INFO_DEPTH)) info_fifo_i (
        .clk(clk), .rst(rst),
        .in_data(info_data), .in_valid(info_valid), .in_ready(info_ready),
        .out_data(info_head), .out_valid(info_head_valid), .out_ready(info_pop)
    );

    // Packet bytes from the receive path
    sync_fifo #(.payload_t(logic [7:0]), .DEPTH(`SNF_DATA_DEPTH)) data_fifo_i (
        .clk(clk), .rst(rst),
        .in_data(usb_data), .in_valid(usb_valid), .in_ready(usb_ready),
        .out_data(data_head), .out_valid(data_head_valid), .out_ready(data_pop)
    );

    byte_counter byte_counter_i (
        .clk(clk), .rst(rst),
        .load(cnt_load), .load_value(cnt_value), .dec(cnt_dec), .zero(cnt_zero)
    );

    reg_access reg_access_i (
        .clk(clk), .rst(rst), .req(req_bus.reg_access),
        .phy_addr(phy_addr), .phy_wdata(phy_wdata),
        .phy_write(phy_write), .phy_read(phy_read),
        .phy_rdata(phy_rdata), .phy_done(phy_done), .read_value(read_value)
    );

    tx_byte_select tx_byte_select_i (
        .clk(clk), .rst(rst), .info_load(info_load), .info(info_head), .sel(sel),
        .data_byte(data_head), .reg_value(read_value), .tx_byte(tx_data)
    );

    main_controller main_controller_i (
        .clk(clk), .rst(rst), .force_send(force_send),
        .op(op_head), .op_valid(op_head_valid), .op_pop(op_pop),
        .info(info_head), .info_valid(info_head_valid), .info_pop(info_pop),
        .data_valid(data_head_valid), .data_pop(data_pop),
        .req(req_bus.controller),
        .cnt_load(cnt_load), .cnt_value(cnt_value), .cnt_dec(cnt_dec), .cnt_zero(cnt_zero),
        .info_load(info_load), .sel(sel),
        .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with first-word fall-through head for any packed payload
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire          clk,
    input  wire          rst,
    input  var payload_t in_data,
    input  wire          in_valid,
    output logic         in_ready,
    output payload_t     out_data,
    output logic         out_valid,
    input  wire          out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];     // Head shows without a pop
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// File: src/tx_byte_select.sv
// UART byte source select
// Latches packet info and picks register, header or data byte for the UART
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

module tx_byte_select (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 info_load,
    input  var sniffer_stream_pkg::pkt_info_t   info,
    input  var sniffer_stream_pkg::tx_sel_t     sel,
    input  wire [7:0]                           data_byte,
    input  wire [7:0]                           reg_value,
    output logic [7:0]                          tx_byte
);

    sniffer_stream_pkg::pkt_info_t info_q;
    logic [7:0]                    hdr_hi;
    logic [7:0]                    hdr_lo;

    always_ff @(posedge clk) begin
        if (!rst)
            info_q <= '0;
        else if (info_load)
            info_q <= info;
    end

    // Header is rxcmd and length, high byte first
    assign hdr_hi = {info_q.rxcmd, info_q.len[`SNF_LEN_W-1:8]};
    assign hdr_lo = info_q.len[7:0];

    always_comb begin
        case (sel)
            sniffer_stream_pkg::SEL_REG:    tx_byte = reg_value;
            sniffer_stream_pkg::SEL_HDR_HI: tx_byte = hdr_hi;
            sniffer_stream_pkg::SEL_HDR_LO: tx_byte = hdr_lo;
            default:                        tx_byte = data_byte;
        endcase
    end

endmodule

`default_nettype wire

// File: testbench/sniffer_cases.txt
// One test per record, hex words: flags (bit 0 pulses force_send), then four counted lists
// op words, packet info words, USB data bytes, expected UART bytes; ffff ends the file

// Write 0x05 with a7, read it back and send it
0000
0003 85a7 c500 4000
0000
0000
0001 a7

// One packet, rxcmd 2d and five data bytes
0000
0001 0000
0001 b405
0005 11 22 33 44 55
0007 b4 05 11 22 33 44 55

// Empty packet sends its header only
0000
0001 0000
0001 4c00
0000
0002 4c 00

// Two packets back to back, the first longer than the data FIFO, then a register round trip
0000
0005 0000 0000 ba5c fa00 4000
0002 fc14 8403
0017 00 ff 01 fe 02 fd 03 fc 04 fb 05 fa 06 f9 07 f8 08 f7 09 f6
     3c 5a 96
001c fc 14 00 ff 01 fe 02 fd 03 fc 04 fb 05 fa 06 f9 07 f8 08 f7 09 f6
     84 03 3c 5a 96 5c

// force_send with no op queued repeats the last read value
0001
0000
0000
0000
0001 5c

ffff

// File: testbench/tb_sniffer.sv
// Testbench for the USB sniffer command controller
// Runs the tests of the cases file against a PHY register model and a UART scoreboard
`timescale 1ns/100ps
`default_nettype none

`include "sniffer_consts.svh"

module tb_sniffer;

    localparam int          CASE_WORDS = 256;
    localparam logic [15:0] END_MARK   = 16'hffff;

    logic                   clk;
    logic                   rst;
    logic                   force_send;
    logic [15:0]            op_data;
    logic [15:0]            info_data;
    logic [7:0]             usb_data;
    logic                   op_valid, op_ready;
    logic                   info_valid, info_ready;
    logic                   usb_valid, usb_ready;
    logic [`SNF_ADDR_W-1:0] phy_addr;
    logic [7:0]             phy_wdata;
    logic [7:0]             phy_rdata;
    logic                   phy_write, phy_read, phy_done;
    logic [7:0]             tx_data;
    logic                   tx_valid, tx_ready;

    logic [15:0] cases_mem [0:CASE_WORDS-1];
    logic [7:0]  phy_regs [0:`SNF_REG_COUNT-1];   // PHY register file model
    logic [7:0]  exp_q [$];                        // UART bytes still expected
    logic [31:0] tx_rng;
    logic [31:0] phy_rng;
    int case_count     = 0;
    int work_items     = 0;
    int case_ptr       = 0;
    int cycle_limit    = 1000000;
    int cycle_count    = 0;
    int check_count    = 0;
    int mismatch_count = 0;
    int error_count    = 0;

    sniffer_top dut_i (
        .clk(clk), .rst(rst), .force_send(force_send),
        .op_data(op_data), .op_valid(op_valid), .op_ready(op_ready),
        .info_data(info_data), .info_valid(info_valid), .info_ready(info_ready),
        .usb_data(usb_data), .usb_valid(usb_valid), .usb_ready(usb_ready),
        .phy_addr(phy_addr), .phy_wdata(phy_wdata), .phy_write(phy_write),
        .phy_read(phy_read), .phy_rdata(phy_rdata), .phy_done(phy_done),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Compares one output with its level right after reset
    task automatic check_reset_level(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Feeders start on a falling edge; ready only moves on the rising edge
    task automatic feed_ops(input int start, input int count);
        for (int i = 0; i < count; i++) begin
            op_data  = cases_mem[start + i];
            op_valid = 1'b1;
            while (!op_ready)
                @(negedge clk);
            @(negedge clk);   // Taken on the edge just passed
        end
        op_valid = 1'b0;
    endtask

    task automatic feed_infos(input int start, input int count);
        for (int i = 0; i < count; i++) begin
            info_data  = cases_mem[start + i];
            info_valid = 1'b1;
            while (!info_ready)
                @(negedge clk);
            @(negedge clk);
        end
        info_valid = 1'b0;
    endtask

    task automatic feed_usb(input int start, input int count);
        for (int i = 0; i < count; i++) begin
            usb_data  = cases_mem[start + i][7:0];
            usb_valid = 1'b1;
            while (!usb_ready)
                @(negedge clk);
            @(negedge clk);
        end
        usb_valid = 1'b0;
    endtask

    // Counts tests and list entries to size the cycle limit
    task automatic scan_cases();
        int p;
        int n;
        p = 0;
        while (p < CASE_WORDS && !$isunknown(cases_mem[p]) && cases_mem[p] != END_MARK) begin
            p++;
            for (int k = 0; k < 4; k++) begin
                n = cases_mem[p];
                work_items += n;
                p += n + 1;
            end
            case_count++;
        end
        if (p >= CASE_WORDS || cases_mem[p] !== END_MARK) begin
            error_count++;
            $display("Cases file ends without its end marker");
        end
        cycle_limit = 100 + 40 * case_count + 16 * work_items;
    endtask

    task automatic run_case();
        logic [15:0] flags;
        logic [15:0] w;
        int op_at, n_op, info_at, n_info, usb_at, n_usb, exp_at, n_exp;
        flags    = cases_mem[case_ptr];
        n_op     = cases_mem[case_ptr + 1];
        op_at    = case_ptr + 2;
        n_info   = cases_mem[op_at + n_op];
        info_at  = op_at + n_op + 1;
        n_usb    = cases_mem[info_at + n_info];
        usb_at   = info_at + n_info + 1;
        n_exp    = cases_mem[usb_at + n_usb];
        exp_at   = usb_at + n_usb + 1;
        case_ptr = exp_at + n_exp;
        for (int i = 0; i < n_exp; i++)
            exp_q.push_back(cases_mem[exp_at + i][7:0]);
        fork
            feed_ops(op_at, n_op);
            feed_infos(info_at, n_info);
            feed_usb(usb_at, n_usb);
        join
        if (flags[0]) begin
            repeat (3) @(negedge clk);  // Op queue empty, controller idle
            force_send = 1'b1;
            @(negedge clk);
            force_send = 1'b0;
        end
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        // Every register written in this test must hold its value
        for (int i = 0; i < n_op; i++) begin
            w = cases_mem[op_at + i];
            if (w[15:14] == sniffer_cmd_pkg::OP_REG_WRITE) begin
                check_count++;
                if (phy_regs[w[13:8]] !== w[7:0]) begin
                    mismatch_count++;
                    $display("Mismatch phy_regs[%h]: got %h, expected %h",
                             w[13:8], phy_regs[w[13:8]], w[7:0]);
                end
            end
        end
    endtask

    task automatic report_counts();
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, error_count);
    endtask

    initial begin
        rst        = 1'b0;
        force_send = 1'b0;
        op_data    = '0;
        op_valid   = 1'b0;
        info_data  = '0;
        info_valid = 1'b0;
        usb_data   = '0;
        usb_valid  = 1'b0;
        $readmemh("testbench/sniffer_cases.txt", cases_mem);
        scan_cases();
        repeat (2) @(negedge clk);
        rst = 1'b1;
        check_reset_level("tx_valid", tx_valid, 1'b0);
        check_reset_level("phy_write", phy_write, 1'b0);
        check_reset_level("phy_read", phy_read, 1'b0);
        check_reset_level("op_ready", op_ready, 1'b1);
        check_reset_level("info_ready", info_ready, 1'b1);
        check_reset_level("usb_ready", usb_ready, 1'b1);
        for (int t = 0; t < case_count; t++)
            run_case();
        repeat (8) @(negedge clk);
        check_count++;
        if (tx_valid) begin
            error_count++;
            $display("UART still offers a byte after the last expected one");
        end
        report_counts();
        if (mismatch_count == 0 && error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // UART sink with random back-pressure that checks each accepted byte in order
    initial begin
        logic [7:0] exp_byte;
        tx_ready = 1'b0;
        tx_rng   = 32'h7d05;
        forever begin
            @(negedge clk);
            tx_rng   = lcg_next(tx_rng);
            tx_ready = tx_rng[29] | tx_rng[22];   // Roughly three cycles in four
            if (rst && tx_valid && tx_ready) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("UART byte %h sent while no byte was expected", tx_data);
                end else begin
                    exp_byte = exp_q.pop_front();
                    check_count++;
                    if (tx_data !== exp_byte) begin
                        mismatch_count++;
                        $display("Mismatch tx_data: got %h, expected %h", tx_data, exp_byte);
                    end
                end
            end
        end
    end

    // PHY register model answering after 1 to 3 cycles
    initial begin
        int delay;
        phy_done  = 1'b0;
        phy_rdata = '0;
        phy_rng   = 32'h7d05;
        for (int a = 0; a < `SNF_REG_COUNT; a++)
            phy_regs[a] = 8'(a * 37 + 17);
        forever begin
            @(negedge clk);
            if (phy_write || phy_read) begin
                phy_rng = lcg_next(phy_rng);
                delay   = 1 + int'(phy_rng[23:16] % 3);
                repeat (delay - 1) @(negedge clk);
                if (phy_write)
                    phy_regs[phy_addr] = phy_wdata;
                else
                    phy_rdata = phy_regs[phy_addr];
                phy_done = 1'b1;
                @(negedge clk);
                phy_done = 1'b0;
            end
        end
    end

    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("Timeout after %0d cycles with %0d UART bytes still expected",
                 cycle_count, exp_q.size());
        report_counts();
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: usb_sniffer.f
+incdir+src
src/sniffer_cmd_pkg.sv
src/sniffer_stream_pkg.sv
src/reg_req_if.sv
src/sync_fifo.sv
src/byte_counter.sv
src/reg_access.sv
src/tx_byte_select.sv
src/main_controller.sv
src/sniffer_top.sv
testbench/tb_sniffer.sv
